//--- rvIsaPkg.sv
package rvIsaPkg;

	typedef logic [31:0] wordT;   // data or address word
	typedef logic [4:0]  regIdxT; // x0..x31
	typedef logic [2:0]  funct3T;
	typedef logic [6:0]  funct7T;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_OP     = 7'b0110011,
		OP_SYSTEM = 7'b1110011
	} opcodeT;

	localparam funct3T F3_JALR = 3'b000;

	localparam funct3T F3_BEQ  = 3'b000;
	localparam funct3T F3_BNE  = 3'b001;
	localparam funct3T F3_BLT  = 3'b100;
	localparam funct3T F3_BGE  = 3'b101;
	localparam funct3T F3_BLTU = 3'b110;
	localparam funct3T F3_BGEU = 3'b111;

	localparam funct3T F3_LB  = 3'b000;
	localparam funct3T F3_LH  = 3'b001;
	localparam funct3T F3_LW  = 3'b010;
	localparam funct3T F3_LBU = 3'b100;
	localparam funct3T F3_LHU = 3'b101;

	localparam funct3T F3_SB = 3'b000;
	localparam funct3T F3_SH = 3'b001;
	localparam funct3T F3_SW = 3'b010;

	// register and immediate ALU ops
	localparam funct3T F3_ADD  = 3'b000; // add, sub
	localparam funct3T F3_SLL  = 3'b001;
	localparam funct3T F3_SLT  = 3'b010;
	localparam funct3T F3_SLTU = 3'b011;
	localparam funct3T F3_XOR  = 3'b100;
	localparam funct3T F3_SR   = 3'b101; // srl, sra
	localparam funct3T F3_OR   = 3'b110;
	localparam funct3T F3_AND  = 3'b111;

	localparam funct7T F7_BASE = 7'b0000000;
	localparam funct7T F7_ALT  = 7'b0100000; // sub, sra, srai

	localparam wordT EBREAK_WORD = 32'h00100073;

endpackage

//--- rvCtrlPkg.sv
package rvCtrlPkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B // lui
	} aluOpT;

	// writeback source
	typedef enum logic [1:0] {
		RES_ALU,
		RES_LOAD,
		RES_PC_PLUS4
	} resSrcT;

	typedef enum logic [1:0] {
		PC_SEQ,
		PC_BRANCH,
		PC_JAL,
		PC_JALR
	} pcSelT;

	typedef enum logic [1:0] {
		SIZE_BYTE,
		SIZE_HALF,
		SIZE_WORD
	} accessSizeT;

	typedef struct packed {
		aluOpT             aluOp;
		logic              srcAIsPc;     // auipc, jal
		logic              srcBIsImm;
		logic              regWrite;
		resSrcT            resSrc;
		logic              memRead;
		logic              memWrite;
		accessSizeT        size;
		logic              loadUnsigned; // lbu, lhu
		pcSelT             pcSel;
		rvIsaPkg::funct3T  branchFunct;
	} ctrlT;

	// does nothing, the decoder starts from here
	localparam ctrlT CTRL_NOP = '{
		aluOp:        ALU_ADD,
		srcAIsPc:     1'b0,
		srcBIsImm:    1'b0,
		regWrite:     1'b0,
		resSrc:       RES_ALU,
		memRead:      1'b0,
		memWrite:     1'b0,
		size:         SIZE_WORD,
		loadUnsigned: 1'b0,
		pcSel:        PC_SEQ,
		branchFunct:  3'b000
	};

	// one retired instruction
	typedef struct packed {
		rvIsaPkg::wordT   pc;
		logic             regWrite;
		rvIsaPkg::regIdxT rd;
		rvIsaPkg::wordT   wdata;
	} retireT;

endpackage

//--- decoder.sv
`timescale 1ns/1ps

module decoder (
	input  rvIsaPkg::wordT   inst,
	output rvCtrlPkg::ctrlT  ctrl,
	output rvIsaPkg::wordT   imm,
	output rvIsaPkg::regIdxT rs1,
	output rvIsaPkg::regIdxT rs2,
	output rvIsaPkg::regIdxT rd,
	output logic             invalid,
	output logic             ebreak
);

	rvIsaPkg::opcodeT opcode;
	rvIsaPkg::funct3T funct3;
	rvIsaPkg::funct7T funct7;
	rvIsaPkg::wordT   immI, immS, immB, immU, immJ;
	logic             legal;

	// funct3 plus the alternate bit to an ALU function
	function automatic rvCtrlPkg::aluOpT aluOpFor(input rvIsaPkg::funct3T f3, input logic alt);
		case (f3)
			rvIsaPkg::F3_ADD:  aluOpFor = alt ? rvCtrlPkg::ALU_SUB : rvCtrlPkg::ALU_ADD;
			rvIsaPkg::F3_SLL:  aluOpFor = rvCtrlPkg::ALU_SLL;
			rvIsaPkg::F3_SLT:  aluOpFor = rvCtrlPkg::ALU_SLT;
			rvIsaPkg::F3_SLTU: aluOpFor = rvCtrlPkg::ALU_SLTU;
			rvIsaPkg::F3_XOR:  aluOpFor = rvCtrlPkg::ALU_XOR;
			rvIsaPkg::F3_SR:   aluOpFor = alt ? rvCtrlPkg::ALU_SRA : rvCtrlPkg::ALU_SRL;
			rvIsaPkg::F3_OR:   aluOpFor = rvCtrlPkg::ALU_OR;
			rvIsaPkg::F3_AND:  aluOpFor = rvCtrlPkg::ALU_AND;
			default:           aluOpFor = rvCtrlPkg::ALU_ADD;
		endcase
	endfunction

	assign opcode = rvIsaPkg::opcodeT'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd     = inst[11:7];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	assign ebreak  = (inst == rvIsaPkg::EBREAK_WORD); // exact word only
	assign invalid = ~legal;

	always_comb begin
		ctrl  = rvCtrlPkg::CTRL_NOP;
		imm   = '0;
		legal = 1'b0;
		case (opcode)
			rvIsaPkg::OP_LUI: begin
				legal          = 1'b1;
				imm            = immU;
				ctrl.aluOp     = rvCtrlPkg::ALU_PASS_B;
				ctrl.srcBIsImm = 1'b1;
				ctrl.regWrite  = 1'b1;
			end
			rvIsaPkg::OP_AUIPC: begin
				legal          = 1'b1;
				imm            = immU;
				ctrl.srcAIsPc  = 1'b1;
				ctrl.srcBIsImm = 1'b1;
				ctrl.regWrite  = 1'b1;
			end
			rvIsaPkg::OP_JAL: begin
				legal          = 1'b1;
				imm            = immJ;
				ctrl.srcAIsPc  = 1'b1;
				ctrl.srcBIsImm = 1'b1;
				ctrl.regWrite  = 1'b1;
				ctrl.resSrc    = rvCtrlPkg::RES_PC_PLUS4; // link
				ctrl.pcSel     = rvCtrlPkg::PC_JAL;
			end
			rvIsaPkg::OP_JALR: begin
				legal          = (funct3 == rvIsaPkg::F3_JALR);
				imm            = immI;
				ctrl.srcBIsImm = 1'b1;
				ctrl.regWrite  = 1'b1;
				ctrl.resSrc    = rvCtrlPkg::RES_PC_PLUS4;
				ctrl.pcSel     = rvCtrlPkg::PC_JALR;
			end
			rvIsaPkg::OP_BRANCH: begin
				legal            = (funct3 != 3'b010) && (funct3 != 3'b011);
				imm              = immB;
				ctrl.pcSel       = rvCtrlPkg::PC_BRANCH;
				ctrl.branchFunct = funct3;
				// beq/bne compare by subtraction, the rest by set-less-than
				if (!funct3[2])
					ctrl.aluOp = rvCtrlPkg::ALU_SUB;
				else if (funct3[1])
					ctrl.aluOp = rvCtrlPkg::ALU_SLTU;
				else
					ctrl.aluOp = rvCtrlPkg::ALU_SLT;
			end
			rvIsaPkg::OP_LOAD: begin
				legal = funct3 inside {rvIsaPkg::F3_LB, rvIsaPkg::F3_LH, rvIsaPkg::F3_LW,
					rvIsaPkg::F3_LBU, rvIsaPkg::F3_LHU};
				imm               = immI;
				ctrl.srcBIsImm    = 1'b1;
				ctrl.regWrite     = 1'b1;
				ctrl.resSrc       = rvCtrlPkg::RES_LOAD;
				ctrl.memRead      = 1'b1;
				ctrl.loadUnsigned = funct3[2];
				case (funct3[1:0])
					2'b00:   ctrl.size = rvCtrlPkg::SIZE_BYTE;
					2'b01:   ctrl.size = rvCtrlPkg::SIZE_HALF;
					default: ctrl.size = rvCtrlPkg::SIZE_WORD;
				endcase
			end
			rvIsaPkg::OP_STORE: begin
				legal = funct3 inside {rvIsaPkg::F3_SB, rvIsaPkg::F3_SH, rvIsaPkg::F3_SW};
				imm            = immS;
				ctrl.srcBIsImm = 1'b1;
				ctrl.memWrite  = 1'b1;
				case (funct3[1:0])
					2'b00:   ctrl.size = rvCtrlPkg::SIZE_BYTE;
					2'b01:   ctrl.size = rvCtrlPkg::SIZE_HALF;
					default: ctrl.size = rvCtrlPkg::SIZE_WORD;
				endcase
			end
			rvIsaPkg::OP_IMM: begin
				imm            = immI;
				ctrl.srcBIsImm = 1'b1;
				ctrl.regWrite  = 1'b1;
				// only srai uses the alternate bit, addi has no subtract form
				ctrl.aluOp = aluOpFor(funct3, (funct3 == rvIsaPkg::F3_SR) && funct7[5]);
				case (funct3)
					rvIsaPkg::F3_SLL: legal = (funct7 == rvIsaPkg::F7_BASE);
					rvIsaPkg::F3_SR:  legal = (funct7 == rvIsaPkg::F7_BASE) ||
						(funct7 == rvIsaPkg::F7_ALT);
					default:          legal = 1'b1;
				endcase
			end
			rvIsaPkg::OP_OP: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluOpFor(funct3, funct7[5]);
				legal = (funct7 == rvIsaPkg::F7_BASE) || ((funct7 == rvIsaPkg::F7_ALT) &&
					(funct3 inside {rvIsaPkg::F3_ADD, rvIsaPkg::F3_SR}));
			end
			rvIsaPkg::OP_SYSTEM: legal = ebreak; // no csr, no ecall
			default: legal = 1'b0;
		endcase
	end

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic             clk,
	input  logic             arstN,
	input  rvIsaPkg::regIdxT rs1,
	input  rvIsaPkg::regIdxT rs2,
	output rvIsaPkg::wordT   rdata1,
	output rvIsaPkg::wordT   rdata2,
	input  logic             we,
	input  rvIsaPkg::regIdxT rd,
	input  rvIsaPkg::wordT   wdata
);

	rvIsaPkg::wordT regs [1:31]; // x0 has no storage

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (rd != '0)) begin
			regs[rd] <= wdata;
		end
	end

	// x0 reads as zero
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
	input  rvCtrlPkg::aluOpT op,
	input  rvIsaPkg::wordT   a,
	input  rvIsaPkg::wordT   b,
	output rvIsaPkg::wordT   result,
	output logic             zero
);

	logic [4:0] shamt;
	logic       lessSigned;
	logic       lessUnsigned;

	assign shamt        = b[4:0];
	assign lessSigned   = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb begin
		case (op)
			rvCtrlPkg::ALU_ADD:    result = a + b;
			rvCtrlPkg::ALU_SUB:    result = a - b;
			rvCtrlPkg::ALU_SLL:    result = a << shamt;
			rvCtrlPkg::ALU_SLT:    result = {31'b0, lessSigned};
			rvCtrlPkg::ALU_SLTU:   result = {31'b0, lessUnsigned};
			rvCtrlPkg::ALU_XOR:    result = a ^ b;
			rvCtrlPkg::ALU_SRL:    result = a >> shamt;
			rvCtrlPkg::ALU_SRA:    result = $signed(a) >>> shamt; // keeps the sign
			rvCtrlPkg::ALU_OR:     result = a | b;
			rvCtrlPkg::ALU_AND:    result = a & b;
			rvCtrlPkg::ALU_PASS_B: result = b;
			default:               result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit #(
	parameter int DMEM_WORDS = 256
) (
	input  logic            clk,
	input  logic            arstN,
	input  rvCtrlPkg::ctrlT ctrl,
	input  logic            we,
	input  rvIsaPkg::wordT  addr,
	input  rvIsaPkg::wordT  storeData,
	output rvIsaPkg::wordT  loadData
);

	localparam int IDX_W = $clog2(DMEM_WORDS);

	rvIsaPkg::wordT   mem [DMEM_WORDS];
	logic [IDX_W-1:0] wordIdx;
	logic [1:0]       byteOff;
	logic [3:0]       laneMask;
	logic [4:0]       laneShift;
	logic             memWe;
	rvIsaPkg::wordT   wrData;
	rvIsaPkg::wordT   rdLane;

	// word index wraps at the array depth
	assign wordIdx = IDX_W'((addr >> 2) % DMEM_WORDS);
	assign byteOff = addr[1:0];

	// lane offset in bits, masked to the access size
	always_comb begin
		case (ctrl.size)
			rvCtrlPkg::SIZE_BYTE: begin
				laneShift = {byteOff, 3'b000};
				laneMask  = 4'b0001 << byteOff;
			end
			rvCtrlPkg::SIZE_HALF: begin
				laneShift = {byteOff[1], 4'b0000};
				laneMask  = 4'b0011 << {byteOff[1], 1'b0};
			end
			default: begin
				laneShift = 5'd0;
				laneMask  = 4'b1111;
			end
		endcase
	end

	assign wrData = storeData << laneShift;
	assign memWe  = we & ctrl.memWrite & arstN; // no stores while reset is held

	always_ff @(posedge clk) begin
		if (memWe) begin
			for (int i = 0; i < 4; i++) begin
				if (laneMask[i])
					mem[wordIdx][i*8 +: 8] <= wrData[i*8 +: 8];
			end
		end
	end

	assign rdLane = mem[wordIdx] >> laneShift;

	always_comb begin
		if (!ctrl.memRead) begin
			loadData = '0;
		end else begin
			case (ctrl.size)
				rvCtrlPkg::SIZE_BYTE:
					loadData = ctrl.loadUnsigned ? {24'b0, rdLane[7:0]} :
						{{24{rdLane[7]}}, rdLane[7:0]};
				rvCtrlPkg::SIZE_HALF:
					loadData = ctrl.loadUnsigned ? {16'b0, rdLane[15:0]} :
						{{16{rdLane[15]}}, rdLane[15:0]};
				default: loadData = rdLane;
			endcase
		end
	end

endmodule

//--- pcUnit.sv
`timescale 1ns/1ps

module pcUnit #(
	parameter rvIsaPkg::wordT RESET_PC = 32'h80000000
) (
	input  logic            clk,
	input  logic            arstN,
	input  rvCtrlPkg::ctrlT ctrl,
	input  rvIsaPkg::wordT  imm,
	input  rvIsaPkg::wordT  aluResult,
	input  rvIsaPkg::wordT  rs1Data,
	input  logic            stop,
	output rvIsaPkg::wordT  pc,
	output rvIsaPkg::wordT  pcPlus4,
	output logic            halted
);

	rvIsaPkg::wordT nextPc;
	rvIsaPkg::wordT target;
	logic           cmpZero; // rs1 == rs2 after the subtract
	logic           cmpLess; // slt or sltu result
	logic           taken;

	assign cmpZero = (aluResult == '0);
	assign cmpLess = aluResult[0];

	always_comb begin
		case (ctrl.branchFunct)
			rvIsaPkg::F3_BEQ:                   taken = cmpZero;
			rvIsaPkg::F3_BNE:                   taken = ~cmpZero;
			rvIsaPkg::F3_BLT, rvIsaPkg::F3_BLTU: taken = cmpLess;
			rvIsaPkg::F3_BGE, rvIsaPkg::F3_BGEU: taken = ~cmpLess;
			default:                            taken = 1'b0;
		endcase
	end

	assign pcPlus4 = pc + 32'd4;
	assign target  = pc + imm; // branch and jal

	always_comb begin
		case (ctrl.pcSel)
			rvCtrlPkg::PC_BRANCH: nextPc = taken ? target : pcPlus4;
			rvCtrlPkg::PC_JAL:    nextPc = target;
			rvCtrlPkg::PC_JALR:   nextPc = (rs1Data + imm) & ~32'd1;
			default:              nextPc = pcPlus4;
		endcase
	end

	// halt is sticky until the next reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc     <= RESET_PC;
			halted <= 1'b0;
		end else if (!halted) begin
			if (stop)
				halted <= 1'b1; // pc stays on the stopping word
			else
				pc <= nextPc;
		end
	end

endmodule

//--- rvCore.sv
`timescale 1ns/1ps

module rvCore #(
	parameter rvIsaPkg::wordT RESET_PC   = 32'h80000000,
	parameter int             DMEM_WORDS = 256
) (
	input  logic              clk,
	input  logic              arstN,
	input  rvIsaPkg::wordT    inst,
	output rvIsaPkg::wordT    pc,
	output rvCtrlPkg::retireT retire,
	output logic              retireValid,
	output logic              halted,
	output logic              invalid
);

	rvCtrlPkg::ctrlT  ctrl;
	rvIsaPkg::wordT   imm;
	rvIsaPkg::regIdxT rs1, rs2, rd;
	rvIsaPkg::wordT   rdata1, rdata2;
	rvIsaPkg::wordT   srcA, srcB;
	rvIsaPkg::wordT   aluResult;
	rvIsaPkg::wordT   loadData;
	rvIsaPkg::wordT   pcPlus4;
	rvIsaPkg::wordT   wbData;
	logic             ebreak;

	decoder u_decoder (
		.inst    (inst),
		.ctrl    (ctrl),
		.imm     (imm),
		.rs1     (rs1),
		.rs2     (rs2),
		.rd      (rd),
		.invalid (invalid),
		.ebreak  (ebreak)
	);

	// nothing retires once stopped or on the stopping word itself
	assign retireValid = ~(halted | invalid | ebreak);

	regFile u_regFile (
		.clk    (clk),
		.arstN  (arstN),
		.rs1    (rs1),
		.rs2    (rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.we     (ctrl.regWrite & retireValid),
		.rd     (rd),
		.wdata  (wbData)
	);

	assign srcA = ctrl.srcAIsPc ? pc : rdata1;
	assign srcB = ctrl.srcBIsImm ? imm : rdata2;

	alu u_alu (
		.op     (ctrl.aluOp),
		.a      (srcA),
		.b      (srcB),
		.result (aluResult),
		.zero   ()
	);

	loadStoreUnit #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_loadStoreUnit (
		.clk       (clk),
		.arstN     (arstN),
		.ctrl      (ctrl),
		.we        (retireValid),
		.addr      (aluResult),
		.storeData (rdata2),
		.loadData  (loadData)
	);

	pcUnit #(
		.RESET_PC (RESET_PC)
	) u_pcUnit (
		.clk       (clk),
		.arstN     (arstN),
		.ctrl      (ctrl),
		.imm       (imm),
		.aluResult (aluResult),
		.rs1Data   (rdata1),
		.stop      (invalid | ebreak),
		.pc        (pc),
		.pcPlus4   (pcPlus4),
		.halted    (halted)
	);

	always_comb begin
		case (ctrl.resSrc)
			rvCtrlPkg::RES_LOAD:     wbData = loadData;
			rvCtrlPkg::RES_PC_PLUS4: wbData = pcPlus4; // jal, jalr link
			default:                 wbData = aluResult;
		endcase
	end

	assign retire = '{pc: pc, regWrite: ctrl.regWrite, rd: rd, wdata: wbData};

endmodule

//--- rvCoreTbProgram.svh
task automatic buildProgram();
	// one row per word address of each phase
	// each row gives name and instruction word, then rd and wdata where a register is written
	curBase = 0;
	// arithmetic and logic
	addWrite("addi x1", opImm(rvIsaPkg::F3_ADD, 5'd1, 5'd0, 12'h005), 5'd1, 32'h5);
	addWrite("addi x2", opImm(rvIsaPkg::F3_ADD, 5'd2, 5'd0, 12'hFFD), 5'd2, 32'hFFFFFFFD);
	addWrite("lui x3", upper(rvIsaPkg::OP_LUI, 5'd3, 20'h80000), 5'd3, 32'h80000000);
	addWrite("auipc x4", upper(rvIsaPkg::OP_AUIPC, 5'd4, 20'h00001), 5'd4, 32'h8000100C);
	addWrite("add x5", opReg(rvIsaPkg::F7_BASE, rvIsaPkg::F3_ADD, 5'd5, 5'd1, 5'd2), 5'd5, 32'h2);
	addWrite("sub x6", opReg(rvIsaPkg::F7_ALT, rvIsaPkg::F3_ADD, 5'd6, 5'd1, 5'd2), 5'd6, 32'h8);
	addWrite("xor x7", opReg(rvIsaPkg::F7_BASE, rvIsaPkg::F3_XOR, 5'd7, 5'd1, 5'd2),
		5'd7, 32'hFFFFFFF8);
	addWrite("or x8", opReg(rvIsaPkg::F7_BASE, rvIsaPkg::F3_OR, 5'd8, 5'd1, 5'd2),
		5'd8, 32'hFFFFFFFD);
	addWrite("and x9", opReg(rvIsaPkg::F7_BASE, rvIsaPkg::F3_AND, 5'd9, 5'd1, 5'd2), 5'd9, 32'h5);
	addWrite("andi x10", opImm(rvIsaPkg::F3_AND, 5'd10, 5'd2, 12'h0F0), 5'd10, 32'hF0);
	addWrite("addi x11", opImm(rvIsaPkg::F3_ADD, 5'd11, 5'd3, 12'hFFF), 5'd11, 32'h7FFFFFFF);
	addWrite("slt x12", opReg(rvIsaPkg::F7_BASE, rvIsaPkg::F3_SLT, 5'd12, 5'd3, 5'd11),
		5'd12, 32'h1);
	addWrite("sltu x13", opReg(rvIsaPkg::F7_BASE, rvIsaPkg::F3_SLTU, 5'd13, 5'd3, 5'd11),
		5'd13, 32'h0);
	addWrite("slti x14", opImm(rvIsaPkg::F3_SLT, 5'd14, 5'd2, 12'h000), 5'd14, 32'h1);
	addWrite("sltiu x15", opImm(rvIsaPkg::F3_SLTU, 5'd15, 5'd1, 12'hFFF), 5'd15, 32'h1);
	addWrite("xori x16", opImm(rvIsaPkg::F3_XOR, 5'd16, 5'd1, 12'hFFF), 5'd16, 32'hFFFFFFFA);
	addWrite("ori x17", opImm(rvIsaPkg::F3_OR, 5'd17, 5'd1, 12'h100), 5'd17, 32'h105);
	// shifts
	addWrite("slli x18", opImm(rvIsaPkg::F3_SLL, 5'd18, 5'd2, 12'h004), 5'd18, 32'hFFFFFFD0);
	addWrite("srli x19", opImm(rvIsaPkg::F3_SR, 5'd19, 5'd2, 12'h01C), 5'd19, 32'hF);
	addWrite("srai x20", opImm(rvIsaPkg::F3_SR, 5'd20, 5'd2, 12'h401), 5'd20, 32'hFFFFFFFE);
	addWrite("sll x21", opReg(rvIsaPkg::F7_BASE, rvIsaPkg::F3_SLL, 5'd21, 5'd1, 5'd1),
		5'd21, 32'hA0);
	addWrite("sra x22", opReg(rvIsaPkg::F7_ALT, rvIsaPkg::F3_SR, 5'd22, 5'd3, 5'd1),
		5'd22, 32'hFC000000);
	addWrite("srl x23", opReg(rvIsaPkg::F7_BASE, rvIsaPkg::F3_SR, 5'd23, 5'd3, 5'd1),
		5'd23, 32'h04000000);
	addWrite("addi x0", opImm(rvIsaPkg::F3_ADD, 5'd0, 5'd1, 12'h007), 5'd0, 32'hC);
	addWrite("add x24", opReg(rvIsaPkg::F7_BASE, rvIsaPkg::F3_ADD, 5'd24, 5'd0, 5'd1),
		5'd24, 32'h5);
	// stores into one word and loads back from every lane
	addWrite("addi x25", opImm(rvIsaPkg::F3_ADD, 5'd25, 5'd0, 12'h100), 5'd25, 32'h100);
	addWrite("lui x26", upper(rvIsaPkg::OP_LUI, 5'd26, 20'h12345), 5'd26, 32'h12345000);
	addWrite("addi x26", opImm(rvIsaPkg::F3_ADD, 5'd26, 5'd26, 12'h678), 5'd26, 32'h12345678);
	addNoWrite("sw x26", store(rvIsaPkg::F3_SW, 5'd26, 5'd25, 12'h000));
	addNoWrite("sh x2", store(rvIsaPkg::F3_SH, 5'd2, 5'd25, 12'h002));
	addNoWrite("sb x1", store(rvIsaPkg::F3_SB, 5'd1, 5'd25, 12'h001));
	addNoWrite("sb x16", store(rvIsaPkg::F3_SB, 5'd16, 5'd25, 12'h000));
	addWrite("lw x27", load(rvIsaPkg::F3_LW, 5'd27, 5'd25, 12'h000), 5'd27, 32'hFFFD05FA);
	addWrite("lh x28", load(rvIsaPkg::F3_LH, 5'd28, 5'd25, 12'h002), 5'd28, 32'hFFFFFFFD);
	addWrite("lhu x29", load(rvIsaPkg::F3_LHU, 5'd29, 5'd25, 12'h002), 5'd29, 32'h0000FFFD);
	addWrite("lh x30", load(rvIsaPkg::F3_LH, 5'd30, 5'd25, 12'h000), 5'd30, 32'h000005FA);
	addWrite("lb x31", load(rvIsaPkg::F3_LB, 5'd31, 5'd25, 12'h000), 5'd31, 32'hFFFFFFFA);
	addWrite("lbu x31", load(rvIsaPkg::F3_LBU, 5'd31, 5'd25, 12'h000), 5'd31, 32'hFA);
	addWrite("lb x30", load(rvIsaPkg::F3_LB, 5'd30, 5'd25, 12'h001), 5'd30, 32'h5);
	addWrite("lbu x29", load(rvIsaPkg::F3_LBU, 5'd29, 5'd25, 12'h002), 5'd29, 32'hFD);
	// branch rows 41 45 47 and 50 are jumped over
	addBranch("beq taken", branch(rvIsaPkg::F3_BEQ, 5'd1, 5'd24, 13'd8), pcOf(42));
	addNoWrite("never reached", NOP_INST);
	addBranch("beq not taken", branch(rvIsaPkg::F3_BEQ, 5'd1, 5'd2, 13'd8), pcOf(43));
	addBranch("bne not taken", branch(rvIsaPkg::F3_BNE, 5'd1, 5'd24, 13'd8), pcOf(44));
	addBranch("bne taken", branch(rvIsaPkg::F3_BNE, 5'd1, 5'd2, 13'd8), pcOf(46));
	addNoWrite("never reached", NOP_INST);
	addBranch("blt taken", branch(rvIsaPkg::F3_BLT, 5'd2, 5'd1, 13'd8), pcOf(48));
	addNoWrite("never reached", NOP_INST);
	addBranch("blt not taken", branch(rvIsaPkg::F3_BLT, 5'd1, 5'd2, 13'd8), pcOf(49));
	addBranch("bgeu taken", branch(rvIsaPkg::F3_BGEU, 5'd2, 5'd1, 13'd8), pcOf(51));
	addNoWrite("never reached", NOP_INST);
	addBranch("bgeu not taken", branch(rvIsaPkg::F3_BGEU, 5'd1, 5'd2, 13'd8), pcOf(52));
	// jumps whose link is pc plus 4
	addLink("jal x5", jal(5'd5, 21'd12), 5'd5, pcOf(55));
	addNoWrite("never reached", NOP_INST);
	addNoWrite("never reached", NOP_INST);
	addWrite("auipc x6", upper(rvIsaPkg::OP_AUIPC, 5'd6, 20'h00000), 5'd6, pcOf(55));
	addLink("jalr x7", jalr(5'd7, 5'd6, 12'd17), 5'd7, pcOf(59)); // odd offset loses bit 0
	addNoWrite("never reached", NOP_INST);
	addNoWrite("never reached", NOP_INST);
	addWrite("sub x8", opReg(rvIsaPkg::F7_ALT, rvIsaPkg::F3_ADD, 5'd8, 5'd7, 5'd5), 5'd8, 32'h10);
	addStop("invalid word", 32'h00000000);
	// second phase after a fresh reset
	curBase = rowTable.size();
	phase2Base = curBase;
	addWrite("addi x9 after reset", opImm(rvIsaPkg::F3_ADD, 5'd9, 5'd9, 12'h055), 5'd9, 32'h55);
	addStop("ebreak", EBREAK_INST);
endtask

//--- rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb;

	localparam rvIsaPkg::wordT RESET_PC    = 32'h80000000;
	localparam rvIsaPkg::wordT NOP_INST    = 32'h00000013; // addi x0, x0, 0
	localparam rvIsaPkg::wordT EBREAK_INST = {12'h001, 5'd0, 3'd0, 5'd0, rvIsaPkg::OP_SYSTEM};

	typedef struct packed {
		rvIsaPkg::wordT   inst;
		logic             valid;
		logic             regWrite;
		rvIsaPkg::regIdxT rd;
		rvIsaPkg::wordT   wdata;
		rvIsaPkg::wordT   nextPc;
	} rowT;

	logic              clk;
	logic              arstN;
	rvIsaPkg::wordT    inst;
	rvIsaPkg::wordT    pc;
	rvCtrlPkg::retireT retire;
	logic              retireValid;
	logic              halted;
	logic              invalid;

	rowT   rowTable[$];
	string rowNames[$];
	int    curBase;
	int    phase2Base;
	int    checkCount;
	int    cycleCount;
	int    cycleLimit;

	rvCore #(
		.RESET_PC   (RESET_PC),
		.DMEM_WORDS (256)
	) u_dut (
		.clk         (clk),
		.arstN       (arstN),
		.inst        (inst),
		.pc          (pc),
		.retire      (retire),
		.retireValid (retireValid),
		.halted      (halted),
		.invalid     (invalid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// instruction encoders
	function automatic rvIsaPkg::wordT opImm(input rvIsaPkg::funct3T f3, input rvIsaPkg::regIdxT rd,
		input rvIsaPkg::regIdxT rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, rvIsaPkg::OP_IMM};
	endfunction

	function automatic rvIsaPkg::wordT opReg(input rvIsaPkg::funct7T f7, input rvIsaPkg::funct3T f3,
		input rvIsaPkg::regIdxT rd, input rvIsaPkg::regIdxT rs1, input rvIsaPkg::regIdxT rs2);
		return {f7, rs2, rs1, f3, rd, rvIsaPkg::OP_OP};
	endfunction

	function automatic rvIsaPkg::wordT upper(input rvIsaPkg::opcodeT op, input rvIsaPkg::regIdxT rd,
		input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic rvIsaPkg::wordT load(input rvIsaPkg::funct3T f3, input rvIsaPkg::regIdxT rd,
		input rvIsaPkg::regIdxT rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, rvIsaPkg::OP_LOAD};
	endfunction

	function automatic rvIsaPkg::wordT store(input rvIsaPkg::funct3T f3, input rvIsaPkg::regIdxT rs2,
		input rvIsaPkg::regIdxT rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rvIsaPkg::OP_STORE};
	endfunction

	function automatic rvIsaPkg::wordT branch(input rvIsaPkg::funct3T f3,
		input rvIsaPkg::regIdxT rs1, input rvIsaPkg::regIdxT rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvIsaPkg::OP_BRANCH};
	endfunction

	function automatic rvIsaPkg::wordT jal(input rvIsaPkg::regIdxT rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvIsaPkg::OP_JAL};
	endfunction

	function automatic rvIsaPkg::wordT jalr(input rvIsaPkg::regIdxT rd, input rvIsaPkg::regIdxT rs1,
		input logic [11:0] imm);
		return {imm, rs1, rvIsaPkg::F3_JALR, rd, rvIsaPkg::OP_JALR};
	endfunction

	// address of word k in the running phase
	function automatic rvIsaPkg::wordT pcOf(input int k);
		return RESET_PC + rvIsaPkg::wordT'(k * 4);
	endfunction

	function automatic rvIsaPkg::wordT followingPc();
		return pcOf(rowTable.size() - curBase + 1);
	endfunction

	task automatic pushRow(input string name, input rvIsaPkg::wordT word, input logic valid,
		input logic regWrite, input rvIsaPkg::regIdxT rd, input rvIsaPkg::wordT wdata,
		input rvIsaPkg::wordT nextPc);
		rowT row;
		row.inst     = word;
		row.valid    = valid;
		row.regWrite = regWrite;
		row.rd       = rd;
		row.wdata    = wdata;
		row.nextPc   = nextPc;
		rowTable.push_back(row);
		rowNames.push_back(name);
	endtask

	task automatic addWrite(input string name, input rvIsaPkg::wordT word,
		input rvIsaPkg::regIdxT rd, input rvIsaPkg::wordT wdata);
		pushRow(name, word, 1'b1, 1'b1, rd, wdata, followingPc());
	endtask

	task automatic addNoWrite(input string name, input rvIsaPkg::wordT word);
		pushRow(name, word, 1'b1, 1'b0, 5'd0, 32'h0, followingPc());
	endtask

	task automatic addBranch(input string name, input rvIsaPkg::wordT word,
		input rvIsaPkg::wordT target);
		pushRow(name, word, 1'b1, 1'b0, 5'd0, 32'h0, target);
	endtask

	task automatic addLink(input string name, input rvIsaPkg::wordT word,
		input rvIsaPkg::regIdxT rd, input rvIsaPkg::wordT target);
		pushRow(name, word, 1'b1, 1'b1, rd, followingPc(), target);
	endtask

	// stopping word, pc must stay put
	task automatic addStop(input string name, input rvIsaPkg::wordT word);
		pushRow(name, word, 1'b0, 1'b0, 5'd0, 32'h0, pcOf(rowTable.size() - curBase));
	endtask

	`include "rvCoreTbProgram.svh"

	task automatic abortRun();
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input rvIsaPkg::wordT expected,
		input rvIsaPkg::wordT actual);
		checkCount++;
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkReg(input string name, input rvIsaPkg::regIdxT expected,
		input rvIsaPkg::regIdxT actual);
		checkCount++;
		if (actual !== expected) begin
			$display("Fail %s: expected x%0d, actual x%0d", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			$display("Fail %s: expected %b, actual %b", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic applyReset();
		@(negedge clk);
		arstN = 1'b0;
		inst  = NOP_INST;
		repeat (2) @(negedge clk);
		arstN = 1'b1;
	endtask

	// follows pc through the table until a stopping row
	task automatic runPhase(input int base, input int len);
		rvIsaPkg::wordT offset;
		rowT            row;
		string          tag;
		int             idx;
		logic           expInvalid;
		logic           stopped;
		stopped = 1'b0;
		while (!stopped) begin
			offset = pc - RESET_PC;
			if (offset[1:0] != 2'b00 || (offset >> 2) >= rvIsaPkg::wordT'(len)) begin
				$display("pc %h is outside the program", pc);
				abortRun();
			end else begin
				idx  = base + int'(offset >> 2);
				row  = rowTable[idx];
				tag  = rowNames[idx];
				inst = row.inst;
				#1;
				expInvalid = !row.valid && (row.inst != EBREAK_INST);
				checkBit({tag, " halted"}, 1'b0, halted);
				checkBit({tag, " retireValid"}, row.valid, retireValid);
				checkBit({tag, " invalid"}, expInvalid, invalid);
				if (row.valid) begin
					checkWord({tag, " retire pc"}, pcOf(idx - base), retire.pc);
					checkBit({tag, " regWrite"}, row.regWrite, retire.regWrite);
					if (row.regWrite) begin
						checkReg({tag, " rd"}, row.rd, retire.rd);
						checkWord({tag, " wdata"}, row.wdata, retire.wdata);
					end
				end
				@(negedge clk);
				checkWord({tag, " next pc"}, row.nextPc, pc);
				stopped = !row.valid;
			end
		end
	endtask

	task automatic holdHalted(input int cycles, input rvIsaPkg::wordT stopPc);
		repeat (cycles) begin
			inst = NOP_INST; // legal word, still must not retire
			#1;
			checkBit("halted", 1'b1, halted);
			checkBit("retireValid while halted", 1'b0, retireValid);
			@(negedge clk);
			checkWord("pc while halted", stopPc, pc);
		end
	endtask

	initial begin
		while (cycleLimit == 0 || cycleCount <= cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
		abortRun();
	end

	initial begin
		arstN      = 1'b0;
		inst       = NOP_INST;
		checkCount = 0;
		cycleCount = 0;
		cycleLimit = 0;
		buildProgram();
		cycleLimit = 2 * rowTable.size() + 20;

		applyReset();
		checkWord("pc after reset", RESET_PC, pc);
		runPhase(0, phase2Base);
		holdHalted(2, pcOf(phase2Base - 1));

		// second phase, registers cleared again
		applyReset();
		checkBit("halted after reset", 1'b0, halted);
		checkWord("pc after second reset", RESET_PC, pc);
		runPhase(phase2Base, rowTable.size() - phase2Base);
		holdHalted(3, pcOf(rowTable.size() - phase2Base - 1));

		if (checkCount > 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("No checks were run");
			abortRun();
		end
	end

endmodule

//--- rvCore.f
+incdir+.
rvIsaPkg.sv
rvCtrlPkg.sv
decoder.sv
regFile.sv
alu.sv
loadStoreUnit.sv
pcUnit.sv
rvCore.sv
rvCoreTb.sv

//--- run.sh
#!/bin/sh
# build and run the rvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module rvCoreTb -f rvCore.f -o rvCoreTbSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

./obj_dir/rvCoreTbSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
	echo "no pass line found in $LOG"
	exit 1
fi
exit 0
